/* Makefile */
TOP := sim_db_tb
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module sim_db -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ) -f build.f
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf $(OBJ) sim.log

/* build.f */
+incdir+testbench
rtl/sim_db_regs_pkg.sv
rtl/sim_db_tacho_pkg.sv
rtl/local_bus_sync.sv
rtl/sim_db_registers.sv
rtl/tacho_pair.sv
rtl/local_bus_read_port.sv
rtl/sim_db.sv
testbench/sim_db_tb.sv

/* rtl/local_bus_read_port.sv */
`timescale 1ns/1ps

module local_bus_read_port
(
  input  logic                       W_clk,
  input  logic                       W_reset_n,
  input  sim_db_regs_pkg::bus_addr_t addr,
  input  sim_db_regs_pkg::bus_data_t rd_value,
  input  logic                       rd_strobe,
  input  logic                       rd_hold,
  input  logic                       cs_sync,
  output sim_db_regs_pkg::bus_data_t rd_data,
  output logic                       rd_data_oe
);

  logic in_window;

  // capture the mux once per read access
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
      rd_data <= '0;
    else if (rd_strobe)
      rd_data <= rd_value;
  end

  assign in_window = (addr[sim_db_regs_pkg::addr_width_c-1 -: 4] ==
                      sim_db_regs_pkg::addr_window_c);

  // board buffer joins rd_data onto the shared bus
  assign rd_data_oe = !cs_sync && rd_hold && in_window;

endmodule

/* rtl/local_bus_sync.sv */
`timescale 1ns/1ps

module local_bus_sync
(
  input  logic W_clk,
  input  logic W_reset_n,
  input  logic cs_n,
  input  logic rd_n,
  input  logic wr_n,
  output logic cs_sync,
  output logic rd_strobe,
  output logic wr_strobe,
  output logic rd_hold
);

  logic cs_s1;
  logic cs_s2;
  logic rd_s1;
  logic rd_s2;
  logic rd_s3;  // extra stage for the read drive tail
  logic wr_s1;
  logic wr_s2;

  // -------------------- synchronizers
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      cs_s1 <= 1'b1;
      cs_s2 <= 1'b1;
      rd_s1 <= 1'b1;
      rd_s2 <= 1'b1;
      rd_s3 <= 1'b1;
      wr_s1 <= 1'b1;
      wr_s2 <= 1'b1;
    end
    else
    begin
      cs_s1 <= cs_n;
      cs_s2 <= cs_s1;
      rd_s1 <= rd_n;
      rd_s2 <= rd_s1;
      rd_s3 <= rd_s2;
      wr_s1 <= wr_n;
      wr_s2 <= wr_s1;
    end
  end

  assign cs_sync = cs_s1 & cs_s2;  // select seen early, released one clock late

  // falling edges while selected
  assign rd_strobe = !cs_s1 && !rd_s1 && rd_s2;
  assign wr_strobe = !cs_s1 && !wr_s1 && wr_s2;

  assign rd_hold = !(rd_s1 && rd_s2 && rd_s3); // two clocks past rd_n rising

  // host never reads and writes in the same access
  strobe_excl_a : assert property (@(posedge W_clk) disable iff (!W_reset_n)
    !(rd_strobe && wr_strobe));

endmodule

/* rtl/sim_db.sv */
`timescale 1ns/1ps

module sim_db
(
  input  logic                                          W_clk,
  input  logic                                          W_reset_n,
  input  sim_db_regs_pkg::bus_addr_t                    addr,
  input  sim_db_regs_pkg::bus_data_t                    wr_data,
  input  logic                                          cs_n,
  input  logic                                          rd_n,
  input  logic                                          wr_n,
  output sim_db_regs_pkg::bus_data_t                    rd_data,
  output logic                                          rd_data_oe,
  output logic [sim_db_regs_pkg::dout_width_c-1:0]      out_n,
  output logic [sim_db_tacho_pkg::channel_count_c-1:0]  spd
);

  localparam int pairs_c = sim_db_tacho_pkg::pair_count_c;

  logic cs_sync;
  logic rd_strobe;
  logic wr_strobe;
  logic rd_hold;
  sim_db_regs_pkg::bus_data_t rd_value;

  sim_db_tacho_pkg::tacho_count_t half_period [pairs_c];
  sim_db_tacho_pkg::tacho_count_t phase [pairs_c];
  sim_db_tacho_pkg::tacho_count_t pulse_limit [pairs_c];
  logic [pairs_c-1:0] limited;
  logic [pairs_c-1:0] load_pulse;
  logic [pairs_c-1:0] finished;
  logic [sim_db_tacho_pkg::channel_count_c-1:0] chan_en;

  // -------------------- bus front end
  local_bus_sync local_bus_sync_inst
  (
    .W_clk     (W_clk),
    .W_reset_n (W_reset_n),
    .cs_n      (cs_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .cs_sync   (cs_sync),
    .rd_strobe (rd_strobe),
    .wr_strobe (wr_strobe),
    .rd_hold   (rd_hold)
  );

  sim_db_registers sim_db_registers_inst
  (
    .W_clk       (W_clk),
    .W_reset_n   (W_reset_n),
    .addr        (addr),
    .wr_data     (wr_data),
    .wr_strobe   (wr_strobe),
    .finished    (finished),
    .rd_value    (rd_value),
    .half_period (half_period),
    .phase       (phase),
    .pulse_limit (pulse_limit),
    .limited     (limited),
    .load_pulse  (load_pulse),
    .chan_en     (chan_en),
    .out_n       (out_n)
  );

  // -------------------- tachometer pairs
  for (genvar p = 0; p < pairs_c; p++)
  begin : g_pair
    tacho_pair tacho_pair_inst
    (
      .W_clk       (W_clk),
      .W_reset_n   (W_reset_n),
      .half_period (half_period[p]),
      .phase       (phase[p]),
      .pulse_limit (pulse_limit[p]),
      .limited     (limited[p]),
      .load_pulse  (load_pulse[p]),
      .chan_en     (chan_en[2*p +: 2]),  // a on even bit, b on odd
      .spd         (spd[2*p +: 2]),
      .finished    (finished[p])
    );
  end

  local_bus_read_port local_bus_read_port_inst
  (
    .W_clk      (W_clk),
    .W_reset_n  (W_reset_n),
    .addr       (addr),
    .rd_value   (rd_value),
    .rd_strobe  (rd_strobe),
    .rd_hold    (rd_hold),
    .cs_sync    (cs_sync),
    .rd_data    (rd_data),
    .rd_data_oe (rd_data_oe)
  );

endmodule

/* rtl/sim_db_registers.sv */
`timescale 1ns/1ps

module sim_db_registers
(
  input  logic                                          W_clk,
  input  logic                                          W_reset_n,
  input  sim_db_regs_pkg::bus_addr_t                    addr,
  input  sim_db_regs_pkg::bus_data_t                    wr_data,
  input  logic                                          wr_strobe,
  input  logic [sim_db_tacho_pkg::pair_count_c-1:0]     finished,
  output sim_db_regs_pkg::bus_data_t                    rd_value,
  output sim_db_tacho_pkg::tacho_count_t                half_period [sim_db_tacho_pkg::pair_count_c],
  output sim_db_tacho_pkg::tacho_count_t                phase [sim_db_tacho_pkg::pair_count_c],
  output sim_db_tacho_pkg::tacho_count_t                pulse_limit [sim_db_tacho_pkg::pair_count_c],
  output logic [sim_db_tacho_pkg::pair_count_c-1:0]     limited,
  output logic [sim_db_tacho_pkg::pair_count_c-1:0]     load_pulse,
  output logic [sim_db_tacho_pkg::channel_count_c-1:0]  chan_en,
  output logic [sim_db_regs_pkg::dout_width_c-1:0]      out_n
);

  localparam int pairs_c = sim_db_tacho_pkg::pair_count_c;
  localparam int chans_c = sim_db_tacho_pkg::channel_count_c;

  logic [pairs_c-1:0] load_q;  // last value written to the load register
  logic [sim_db_regs_pkg::dout_width_c-1:0] dout_q;

  sim_db_regs_pkg::bus_addr_t half_addr [pairs_c];
  sim_db_regs_pkg::bus_addr_t phase_addr [pairs_c];
  sim_db_regs_pkg::bus_addr_t pulse_addr [pairs_c];

  // -------------------- per pair addresses
  for (genvar p = 0; p < pairs_c; p++)
  begin : g_addr
    assign half_addr[p] = sim_db_regs_pkg::half_base_c +
      sim_db_regs_pkg::bus_addr_t'(p * sim_db_regs_pkg::half_stride_c);
    assign phase_addr[p] = sim_db_regs_pkg::phase_base_c +
      sim_db_regs_pkg::bus_addr_t'(p * sim_db_regs_pkg::phase_stride_c);
    assign pulse_addr[p] = sim_db_regs_pkg::pulse_base_c +
      sim_db_regs_pkg::bus_addr_t'(p * sim_db_regs_pkg::pulse_stride_c);
  end

  // -------------------- write side
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      limited <= '0;
      chan_en <= '0;
      load_q <= '0;
      load_pulse <= '0;
      dout_q <= '0;
      for (int p = 0; p < pairs_c; p++)
      begin
        half_period[p] <= '0;
        phase[p] <= '0;
        pulse_limit[p] <= '0;
      end
    end
    else
    begin
      load_pulse <= '0;  // single clock unless rewritten
      if (wr_strobe)
      begin
        case (addr)
          sim_db_regs_pkg::mode_addr_c: limited <= wr_data[pairs_c-1:0];
          sim_db_regs_pkg::chan_en_addr_c: chan_en <= wr_data[chans_c-1:0];
          sim_db_regs_pkg::load_addr_c:
          begin
            load_q <= wr_data[pairs_c-1:0];
            load_pulse <= wr_data[pairs_c-1:0];
          end
          sim_db_regs_pkg::dout_addr_c: dout_q <= wr_data[sim_db_regs_pkg::dout_width_c-1:0];
          default: ;
        endcase
        for (int p = 0; p < pairs_c; p++)
        begin
          if (addr == half_addr[p])
            half_period[p] <= wr_data;
          if (addr == phase_addr[p])
            phase[p] <= wr_data;
          if (addr == pulse_addr[p])
            pulse_limit[p] <= wr_data;
        end
      end
    end
  end

  assign out_n = ~dout_q;  // pins are active low

  // -------------------- read mux
  always_comb
  begin
    rd_value = '0;
    case (addr)
      sim_db_regs_pkg::version_addr_c: rd_value = sim_db_regs_pkg::version_c;
      sim_db_regs_pkg::pat_aaaa_addr_c: rd_value = sim_db_regs_pkg::pat_aaaa_c;
      sim_db_regs_pkg::pat_5555_addr_c: rd_value = sim_db_regs_pkg::pat_5555_c;
      sim_db_regs_pkg::pat_ffff_addr_c: rd_value = sim_db_regs_pkg::pat_ffff_c;
      sim_db_regs_pkg::pat_0000_addr_c: rd_value = sim_db_regs_pkg::pat_0000_c;
      sim_db_regs_pkg::mode_addr_c: rd_value[pairs_c-1:0] = limited;
      sim_db_regs_pkg::chan_en_addr_c: rd_value[chans_c-1:0] = chan_en;
      sim_db_regs_pkg::load_addr_c: rd_value[pairs_c-1:0] = load_q;
      sim_db_regs_pkg::finished_addr_c: rd_value[pairs_c-1:0] = finished;
      sim_db_regs_pkg::dout_addr_c: rd_value[sim_db_regs_pkg::dout_width_c-1:0] = dout_q;
      default: ;
    endcase
    for (int p = 0; p < pairs_c; p++)
    begin
      if (addr == half_addr[p])
        rd_value = half_period[p];
      if (addr == phase_addr[p])
        rd_value = phase[p];
      if (addr == pulse_addr[p])
        rd_value = pulse_limit[p];
    end
  end

  // one restart per bus write, even with a long strobe
  load_single_a : assert property (@(posedge W_clk) disable iff (!W_reset_n)
    (load_pulse != '0) |=> (load_pulse == '0));

endmodule

/* rtl/sim_db_regs_pkg.sv */
package sim_db_regs_pkg;

  // -------------------- bus widths
  localparam int addr_width_c = 12;
  localparam int data_width_c = 16;

  typedef logic [addr_width_c-1:0] bus_addr_t;
  typedef logic [data_width_c-1:0] bus_data_t;

  localparam logic [3:0] addr_window_c = 4'h8; // block answers in 0x8xx

  // -------------------- fixed words
  localparam bus_addr_t version_addr_c = 12'h800;
  localparam bus_addr_t pat_aaaa_addr_c = 12'h802;
  localparam bus_addr_t pat_5555_addr_c = 12'h804;
  localparam bus_addr_t pat_ffff_addr_c = 12'h806;
  localparam bus_addr_t pat_0000_addr_c = 12'h808;

  localparam bus_data_t version_c = 16'hb616;
  localparam bus_data_t pat_aaaa_c = 16'haaaa;
  localparam bus_data_t pat_5555_c = 16'h5555;
  localparam bus_data_t pat_ffff_c = 16'hffff;
  localparam bus_data_t pat_0000_c = 16'h0000;

  // -------------------- control registers
  localparam bus_addr_t mode_addr_c = 12'h810;     // bit p, limited mode
  localparam bus_addr_t chan_en_addr_c = 12'h812;  // bits 2p/2p+1, channel a/b
  localparam bus_addr_t load_addr_c = 12'h814;     // bit p, restart pair
  localparam bus_addr_t finished_addr_c = 12'h870; // read only
  localparam bus_addr_t dout_addr_c = 12'h890;

  localparam int dout_width_c = 2;

  // per pair blocks, base plus pair index times stride
  localparam bus_addr_t half_base_c = 12'h820;
  localparam int half_stride_c = 4;
  localparam bus_addr_t phase_base_c = 12'h840;
  localparam int phase_stride_c = 4;
  localparam bus_addr_t pulse_base_c = 12'h860;
  localparam int pulse_stride_c = 2;

endpackage

/* rtl/sim_db_tacho_pkg.sv */
package sim_db_tacho_pkg;

  // -------------------- pair layout
  localparam int pair_count_c = 2;
  localparam int channel_count_c = 2 * pair_count_c; // a and b per pair

  localparam int count_width_c = 16;

  // half period, phase lag and pulse limit all share this width
  typedef logic [count_width_c-1:0] tacho_count_t;

  // -------------------- pair state
  typedef enum logic [1:0]
  {
    idle,
    running,
    done     // limited run complete, flag raised
  } tacho_state_t;

endpackage

/* rtl/tacho_pair.sv */
`timescale 1ns/1ps

module tacho_pair
(
  input  logic                           W_clk,
  input  logic                           W_reset_n,
  input  sim_db_tacho_pkg::tacho_count_t half_period,
  input  sim_db_tacho_pkg::tacho_count_t phase,
  input  sim_db_tacho_pkg::tacho_count_t pulse_limit,
  input  logic                           limited,
  input  logic                           load_pulse,
  input  logic [1:0]                     chan_en,
  output logic [1:0]                     spd,
  output logic                           finished
);

  sim_db_tacho_pkg::tacho_state_t state;

  sim_db_tacho_pkg::tacho_count_t half_q;   // latched on load
  sim_db_tacho_pkg::tacho_count_t limit_q;
  logic limited_q;

  sim_db_tacho_pkg::tacho_count_t half_cnt_a;
  sim_db_tacho_pkg::tacho_count_t half_cnt_b;
  sim_db_tacho_pkg::tacho_count_t dly_cnt;  // remaining lag of channel b
  sim_db_tacho_pkg::tacho_count_t pulse_cnt;

  logic lvl_a;
  logic lvl_b;
  logic b_run;   // channel b past its lag
  logic a_toggle;
  logic b_toggle;

  assign a_toggle = (half_cnt_a == half_q - 16'd1);
  assign b_toggle = (half_cnt_b == half_q - 16'd1);

  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      state <= sim_db_tacho_pkg::idle;
      half_q <= '0;
      limit_q <= '0;
      limited_q <= 1'b0;
      half_cnt_a <= '0;
      half_cnt_b <= '0;
      dly_cnt <= '0;
      pulse_cnt <= '0;
      lvl_a <= 1'b0;
      lvl_b <= 1'b0;
      b_run <= 1'b0;
    end
    else if (load_pulse)
    begin
      half_q <= half_period;
      limit_q <= pulse_limit;
      limited_q <= limited;
      half_cnt_a <= '0;
      half_cnt_b <= '0;
      pulse_cnt <= '0;
      lvl_a <= 1'b1;              // a starts high next cycle
      dly_cnt <= phase;
      b_run <= (phase == '0);     // b tracks a when there is no lag
      lvl_b <= (phase == '0);
      state <= (half_period < 16'd2) ? sim_db_tacho_pkg::idle : sim_db_tacho_pkg::running;
    end
    else if (state == sim_db_tacho_pkg::running)
    begin
      // -------------------- channel a
      if (a_toggle)
      begin
        half_cnt_a <= '0;
        lvl_a <= !lvl_a;
      end
      else
        half_cnt_a <= half_cnt_a + 16'd1;

      if (a_toggle && lvl_a)      // falling edge of a
      begin
        pulse_cnt <= pulse_cnt + 16'd1;
        if (limited_q && pulse_cnt == limit_q - 16'd1)
          state <= sim_db_tacho_pkg::done;
      end

      // -------------------- channel b
      if (!b_run)
      begin
        if (dly_cnt == 16'd1)
        begin
          b_run <= 1'b1;
          lvl_b <= 1'b1;
          half_cnt_b <= '0;
        end
        else
          dly_cnt <= dly_cnt - 16'd1;
      end
      else if (b_toggle)
      begin
        half_cnt_b <= '0;
        lvl_b <= !lvl_b;
      end
      else
        half_cnt_b <= half_cnt_b + 16'd1;
    end
  end

  assign spd[0] = (state == sim_db_tacho_pkg::running) && lvl_a && chan_en[0];
  assign spd[1] = (state == sim_db_tacho_pkg::running) && b_run && lvl_b && chan_en[1];
  assign finished = (state == sim_db_tacho_pkg::done);

  // a limited run stops on a falling edge of a after the full count
  done_quiet_a : assert property (@(posedge W_clk) disable iff (!W_reset_n)
    finished |-> (!lvl_a && pulse_cnt == limit_q));

endmodule

/* testbench/sim_db_tb_tests.svh */
// -------------------- setup helpers
task automatic setup_pair(input int p, input int h, input int lag, input int limit,
                          input logic limit_on);
  bus_write(half_addr(p), 16'(h));
  bus_write(phase_addr(p), 16'(lag));
  bus_write(pulse_addr(p), 16'(limit));
  bus_write(sim_db_regs_pkg::mode_addr_c, limit_on ? 16'(1 << p) : 16'h0);
  bus_write(sim_db_regs_pkg::chan_en_addr_c, 16'hf);  // all channels on
endtask

task automatic load_pairs(input int mask);
  bus_write(sim_db_regs_pkg::load_addr_c, 16'(mask));
endtask

task automatic write_read(input string what, input sim_db_regs_pkg::bus_addr_t a,
                          input sim_db_regs_pkg::bus_data_t mask,
                          output sim_db_regs_pkg::bus_data_t v);
  v = 16'($random(seed));
  bus_write(a, v);
  read_expect(what, a, v & mask);
endtask

// -------------------- directed tests
task automatic test_reset_defaults();
  sim_db_regs_pkg::bus_data_t d;
  logic oe;
  test_name = "reset_defaults";
  @(negedge W_clk);
  check_equal("spd", 32'h0, 32'(spd));
  check_equal("out_n", 32'h3, 32'(out_n));
  check_equal("idle drive", 32'h0, 32'(rd_data_oe));
  read_expect("version", 12'h800, 16'hb616);
  read_expect("pattern 0x802", 12'h802, 16'haaaa);
  read_expect("pattern 0x804", 12'h804, 16'h5555);
  read_expect("pattern 0x806", 12'h806, 16'hffff);
  read_expect("pattern 0x808", 12'h808, 16'h0000);
  read_expect("mode", sim_db_regs_pkg::mode_addr_c, 16'h0);
  read_expect("finished", sim_db_regs_pkg::finished_addr_c, 16'h0);
  bus_read(12'h700, d, oe);  // outside the 0x8xx window
  check_equal("outside drive", 32'h0, 32'(oe));
endtask

task automatic test_register_readback();
  sim_db_regs_pkg::bus_data_t v;
  test_name = "register_readback";
  write_read("mode", sim_db_regs_pkg::mode_addr_c, 16'h3, v);
  write_read("channel enable", sim_db_regs_pkg::chan_en_addr_c, 16'hf, v);
  write_read("load", sim_db_regs_pkg::load_addr_c, 16'h3, v);
  for (int p = 0; p < pairs_c; p++)
  begin
    write_read($sformatf("half period %0d", p), half_addr(p), 16'hffff, v);
    write_read($sformatf("phase %0d", p), phase_addr(p), 16'hffff, v);
    write_read($sformatf("pulse count %0d", p), pulse_addr(p), 16'hffff, v);
  end
  write_read("digital out", sim_db_regs_pkg::dout_addr_c, 16'h3, v);
  @(negedge W_clk);
  check_equal("out_n", 32'(v[1:0] ^ 2'b11), 32'(out_n));  // pins active low
endtask

task automatic test_period();
  int h;
  int high_len;
  int period_len;
  test_name = "period";
  for (int p = 0; p < pairs_c; p++)
  begin
    h = random_half();
    setup_pair(p, h, 0, 0, 1'b0);
    load_pairs(1 << p);
    measure_pulse(2 * p, high_len, period_len);
    check_equal($sformatf("pair %0d high time", p), 32'(h), 32'(high_len));
    check_equal($sformatf("pair %0d period", p), 32'(2 * h), 32'(period_len));
  end
endtask

task automatic test_phase_lag();
  int h;
  int lag;
  int n;
  logic prev_a;
  logic prev_b;
  test_name = "phase_lag";
  for (int p = 0; p < pairs_c; p++)
  begin
    h = random_half();
    lag = random_below(2 * h);
    setup_pair(p, h, lag, 0, 1'b0);
    load_pairs(1 << p);
    @(negedge W_clk);
    prev_a = spd[2 * p];
    prev_b = spd[2 * p + 1];
    @(negedge W_clk);
    while (!(spd[2 * p] && !prev_a))  // hunt for a rise on channel a
    begin
      prev_a = spd[2 * p];
      prev_b = spd[2 * p + 1];
      @(negedge W_clk);
    end
    n = 0;
    while (!(spd[2 * p + 1] && !prev_b))
    begin
      prev_b = spd[2 * p + 1];
      @(negedge W_clk);
      n++;
    end
    check_equal($sformatf("pair %0d lag", p), 32'(lag), 32'(n));
  end
endtask

task automatic test_pulse_limit();
  int h;
  int rises;
  test_name = "pulse_limit";
  for (int p = 0; p < pairs_c; p++)
  begin
    h = random_half();
    setup_pair(p, 0, 0, 0, 1'b0);
    load_pairs(1 << p);  // half period 0 parks the pair
    @(negedge W_clk);
    check_equal("parked", 32'h0, 32'(spd[2 * p +: 2]));
    setup_pair(p, h, 0, 5, 1'b1);
    fork
      load_pairs(1 << p);
      count_rises(2 * p, 14 * h + 30, rises);
    join
    check_equal($sformatf("pair %0d pulses", p), 32'd5, 32'(rises));
    check_equal("quiet after limit", 32'h0, 32'(spd[2 * p +: 2]));
    read_expect("finished", sim_db_regs_pkg::finished_addr_c, 16'(1 << p));
    load_pairs(1 << p);
    read_expect("finished after load", sim_db_regs_pkg::finished_addr_c, 16'h0);
    bus_write(half_addr(p), 16'h0);
    load_pairs(1 << p);
  end
endtask

task automatic test_channel_disable();
  int h;
  int rises;
  logic prev;
  test_name = "channel_disable";
  h = random_half();
  setup_pair(1, h, random_below(2 * h), 0, 1'b0);
  load_pairs(2);
  bus_write(sim_db_regs_pkg::chan_en_addr_c, 16'h7);  // pair 1 channel b off
  @(negedge W_clk);
  prev = spd[2];
  rises = 0;
  repeat (4 * h)
  begin
    @(negedge W_clk);
    check_equal("pair 1 channel b", 32'h0, 32'(spd[3]));
    if (spd[2] && !prev)
      rises++;
    prev = spd[2];
  end
  check_equal("pair 1 channel a rises", 32'd2, 32'(rises));  // two periods in 4H
endtask

/* testbench/sim_db_tb.sv */
`timescale 1ns/1ps

module sim_db_tb;

  localparam int pairs_c = sim_db_tacho_pkg::pair_count_c;
  localparam int chans_c = sim_db_tacho_pkg::channel_count_c;
  localparam int max_half_c = 63;
  localparam int level_wait_c = 4 * max_half_c + 20;

  // longest test runs ~6 pulses of 2*63 clocks per pair, about 1.6k clocks,
  // plus ~90 bus accesses of 12 clocks; rounded up well
  localparam int timeout_cycles_c = 20000;

  logic W_clk;
  logic W_reset_n;
  sim_db_regs_pkg::bus_addr_t addr;
  sim_db_regs_pkg::bus_data_t wr_data;
  logic cs_n;
  logic rd_n;
  logic wr_n;
  sim_db_regs_pkg::bus_data_t rd_data;
  logic rd_data_oe;
  logic [sim_db_regs_pkg::dout_width_c-1:0] out_n;
  logic [chans_c-1:0] spd;

  integer seed;
  int cycle_count = 0;
  string test_name;

  sim_db sim_db_inst
  (
    .W_clk      (W_clk),
    .W_reset_n  (W_reset_n),
    .addr       (addr),
    .wr_data    (wr_data),
    .cs_n       (cs_n),
    .rd_n       (rd_n),
    .wr_n       (wr_n),
    .rd_data    (rd_data),
    .rd_data_oe (rd_data_oe),
    .out_n      (out_n),
    .spd        (spd)
  );

  always #10 W_clk = ~W_clk;  // 20 ns period

  // -------------------- watchdog
  always @(posedge W_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles_c)
    begin
      $display("run stopped, no end after %0d clocks during %s", cycle_count, test_name);
      end_with_failure();
    end
  end

  task automatic end_with_failure();
    $display("Verification failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("CHECK FAILED %s %s expected 0x%0h actual 0x%0h",
               test_name, what, expected, actual);
      end_with_failure();
    end
  endtask

  // -------------------- address map and random values
  function automatic sim_db_regs_pkg::bus_addr_t half_addr(input int p);
    return sim_db_regs_pkg::half_base_c + 12'(p * sim_db_regs_pkg::half_stride_c);
  endfunction

  function automatic sim_db_regs_pkg::bus_addr_t phase_addr(input int p);
    return sim_db_regs_pkg::phase_base_c + 12'(p * sim_db_regs_pkg::phase_stride_c);
  endfunction

  function automatic sim_db_regs_pkg::bus_addr_t pulse_addr(input int p);
    return sim_db_regs_pkg::pulse_base_c + 12'(p * sim_db_regs_pkg::pulse_stride_c);
  endfunction

  function automatic int random_below(input int limit);
    return ($random(seed) & 32'h7fff_ffff) % limit;
  endfunction

  function automatic int random_half();
    return 2 + random_below(max_half_c - 1);  // 2 to 63
  endfunction

  // -------------------- bus access
  task automatic bus_write(input sim_db_regs_pkg::bus_addr_t a,
                           input sim_db_regs_pkg::bus_data_t d);
    @(posedge W_clk);
    addr <= a;
    wr_data <= d;
    cs_n <= 1'b0;
    wr_n <= 1'b0;
    repeat (8) @(posedge W_clk);
    cs_n <= 1'b1;
    wr_n <= 1'b1;
    repeat (3) @(posedge W_clk);  // strobe sync back to idle
  endtask

  task automatic bus_read(input sim_db_regs_pkg::bus_addr_t a,
                          output sim_db_regs_pkg::bus_data_t d, output logic oe);
    @(posedge W_clk);
    addr <= a;
    cs_n <= 1'b0;
    rd_n <= 1'b0;
    repeat (7) @(posedge W_clk);
    @(negedge W_clk);  // last cycle of the access
    d = rd_data;
    oe = rd_data_oe;
    @(posedge W_clk);
    cs_n <= 1'b1;
    rd_n <= 1'b1;
    repeat (3) @(posedge W_clk);
  endtask

  task automatic read_expect(input string what, input sim_db_regs_pkg::bus_addr_t a,
                             input sim_db_regs_pkg::bus_data_t expected);
    sim_db_regs_pkg::bus_data_t d;
    logic oe;
    bus_read(a, d, oe);
    check_equal({what, " drive"}, 32'h1, 32'(oe));
    check_equal(what, 32'(expected), 32'(d));
  endtask

  // -------------------- channel observation, sampled on falling clock edges
  task automatic wait_level(input int chan, input logic level);
    int n;
    n = 0;
    do
    begin
      @(negedge W_clk);
      n++;
    end
    while (spd[chan] !== level && n < level_wait_c);
    if (spd[chan] !== level)
    begin
      $display("spd bit %0d never reached %0b within %0d clocks", chan, level, n);
      end_with_failure();
    end
  endtask

  task automatic measure_pulse(input int chan, output int high_len, output int period_len);
    int n;
    wait_level(chan, 1'b0);
    wait_level(chan, 1'b1);  // first sample after a rise
    n = 0;
    while (spd[chan] == 1'b1)
    begin
      @(negedge W_clk);
      n++;
    end
    high_len = n;
    while (spd[chan] == 1'b0)
    begin
      @(negedge W_clk);
      n++;
    end
    period_len = n;
  endtask

  task automatic count_rises(input int chan, input int cycles, output int rises);
    logic prev;
    int n;
    @(negedge W_clk);
    prev = spd[chan];
    n = 0;
    repeat (cycles)
    begin
      @(negedge W_clk);
      if (spd[chan] && !prev)
        n++;
      prev = spd[chan];
    end
    rises = n;
  endtask

  `include "sim_db_tb_tests.svh"

  // -------------------- test sequence
  initial
  begin
    W_clk = 1'b0;
    W_reset_n <= 1'b0;
    addr <= '0;
    wr_data <= '0;
    cs_n <= 1'b1;
    rd_n <= 1'b1;
    wr_n <= 1'b1;
    seed = 89;
    test_name = "reset";
    repeat (4) @(posedge W_clk);
    W_reset_n <= 1'b1;

    test_reset_defaults();
    test_register_readback();
    test_period();
    test_phase_lag();
    test_pulse_limit();
    test_channel_disable();

    $display("Verification passed");
    $finish;
  end

endmodule
